//--- list.f
logic/rv32i_pkg.sv
logic/id_ex_if.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv32i_core.sv
test/tb_clock_gen.sv
test/tb_rv32i_core.sv

//--- logic/decode_stage.sv
// Decode stage. Splits the instruction word, builds the immediate,
// picks the ALU operation and registers the ID/EX bundle.
// Register reads go out to reg_file and come back the same cycle.

`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  rv32i_pkg::word_t    instr,
    output rv32i_pkg::reg_idx_t rs1,
    output rv32i_pkg::reg_idx_t rs2,
    input  rv32i_pkg::word_t    rs1_data,
    input  rv32i_pkg::word_t    rs2_data,
    id_ex_if.decode             id_ex
);
    import rv32i_pkg::*;

    instr_u  iw;
    logic    supported;
    logic    use_imm_d;
    alu_op_e alu_op_d;
    word_t   imm_d;

    assign iw = instr;

    // Source fields sit at the same bits in every format used here
    assign rs1 = iw.r.rs1;
    assign rs2 = iw.r.rs2;

    // ------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------
    always_comb begin
        supported = 1'b0;
        use_imm_d = 1'b0;
        alu_op_d  = alu_add;
        // Sign-extended I immediate unless LUI overrides
        imm_d     = {{20{iw.i.imm[11]}}, iw.i.imm};
        case (iw.r.opcode)
            opc_op: begin
                supported = 1'b1;
                case (iw.r.funct3)
                    3'b000:  alu_op_d = iw.r.funct7[5] ? alu_sub : alu_add;
                    3'b001:  alu_op_d = alu_sll;
                    3'b010:  alu_op_d = alu_slt;
                    3'b011:  alu_op_d = alu_sltu;
                    3'b100:  alu_op_d = alu_xor;
                    3'b101:  alu_op_d = iw.r.funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op_d = alu_or;
                    default: alu_op_d = alu_and;
                endcase
            end
            opc_op_imm: begin
                supported = 1'b1;
                use_imm_d = 1'b1;
                // No SUBI, bit 30 only splits SRLI from SRAI
                case (iw.i.funct3)
                    3'b000:  alu_op_d = alu_add;
                    3'b001:  alu_op_d = alu_sll;
                    3'b010:  alu_op_d = alu_slt;
                    3'b011:  alu_op_d = alu_sltu;
                    3'b100:  alu_op_d = alu_xor;
                    3'b101:  alu_op_d = iw.r.funct7[5] ? alu_sra : alu_srl;
                    3'b110:  alu_op_d = alu_or;
                    default: alu_op_d = alu_and;
                endcase
            end
            opc_lui: begin
                supported = 1'b1;
                use_imm_d = 1'b1;
                alu_op_d  = alu_pass_b;
                imm_d     = {iw.u.imm, 12'b0};
            end
            default: begin
                // Unsupported, falls out as a bubble
                supported = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------
    // rd of x0 is dropped here so later stages never see it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= instr_valid && supported && (iw.r.rd != '0);
        end
    end

    // Payload, qualified by valid
    always_ff @(posedge clk) begin
        id_ex.rd       <= iw.r.rd;
        id_ex.rs1      <= rs1;
        id_ex.rs2      <= rs2;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm_d;
        id_ex.use_imm  <= use_imm_d;
        id_ex.alu_op   <= alu_op_d;
    end

    // alu_op is only meaningful when its control fields are known
    a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> !$isunknown({iw.r.opcode, iw.r.funct3, iw.r.funct7[5]}));

endmodule

//--- logic/execute_stage.sv
// Execute stage. Forwards the previous result into the operands,
// runs the ALU and registers the EX/WB result.
// The EX/WB outputs are also the register file write port.

`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    id_ex_if.execute            id_ex,
    output logic                wb_valid,
    output rv32i_pkg::reg_idx_t wb_rd,
    output rv32i_pkg::word_t    wb_data
);
    import rv32i_pkg::*;

    logic       fwd_a;
    logic       fwd_b;
    word_t      op_a;
    word_t      op_b_reg;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_res;

    // ------------------------------------------------------------
    // Forwarding from EX/WB
    // ------------------------------------------------------------
    // Distance two is covered by the register file bypass
    assign fwd_a = wb_valid && (wb_rd != '0) && (wb_rd == id_ex.rs1);
    assign fwd_b = wb_valid && (wb_rd != '0) && (wb_rd == id_ex.rs2);

    assign op_a     = fwd_a ? wb_data : id_ex.rs1_data;
    assign op_b_reg = fwd_b ? wb_data : id_ex.rs2_data;
    // Immediate wins after forwarding, so a stray rs2 match is harmless
    assign op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;

    // Only the low five bits shift
    assign shamt = op_b[4:0];

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    always_comb begin
        case (id_ex.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_sll:    alu_res = op_a << shamt;
            alu_slt:    alu_res = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu:   alu_res = word_t'(op_a < op_b);
            alu_xor:    alu_res = op_a ^ op_b;
            alu_srl:    alu_res = op_a >> shamt;
            alu_sra:    alu_res = word_t'($signed(op_a) >>> shamt);
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // ------------------------------------------------------------
    // EX/WB register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= id_ex.valid;
        end
    end

    // Data and index ride along with valid
    always_ff @(posedge clk) begin
        wb_rd   <= id_ex.rd;
        wb_data <= alu_res;
    end

    // Decode filters x0 targets, so no writeback ever names x0
    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0);

endmodule

//--- logic/id_ex_if.sv
// Decoded instruction bundle between decode and execute.
// Decode registers every field, execute only reads them.

`timescale 1ns/1ps

interface id_ex_if;
    import rv32i_pkg::*;

    // Strobe, no handshake
    logic     valid;
    // Destination and source indices
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    // Register file read data, sampled in decode
    word_t    rs1_data;
    word_t    rs2_data;
    // Immediate and operand B select
    word_t    imm;
    logic     use_imm;
    alu_op_e  alu_op;

    // Producer side
    modport decode (
        output valid, rd, rs1, rs2, rs1_data, rs2_data, imm, use_imm, alu_op
    );

    // Consumer side
    modport execute (
        input valid, rd, rs1, rs2, rs1_data, rs2_data, imm, use_imm, alu_op
    );

endinterface

//--- logic/reg_file.sv
// Architectural register file, two read ports and one write port.
// Reads are combinational and see the write of the same cycle.
// NUM_REGS of 16 gives an RV32E-style file.

`timescale 1ns/1ps

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  rv32i_pkg::reg_idx_t rs1,
    input  rv32i_pkg::reg_idx_t rs2,
    output rv32i_pkg::word_t   rs1_data,
    output rv32i_pkg::word_t   rs2_data,
    input  logic               wr_en,
    input  rv32i_pkg::reg_idx_t wr_rd,
    input  rv32i_pkg::word_t   wr_data
);
    import rv32i_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_hit;

    // Writes to x0 or past the end of the file are dropped
    assign wr_hit = wr_en && (wr_rd != '0) && (int'(wr_rd) < NUM_REGS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // x0 and absent registers read zero, current write bypasses the array
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0 || int'(idx) >= NUM_REGS) begin
            return '0;
        end
        if (wr_hit && wr_rd == idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

    // Write port never presents a write to x0
    a_wr_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_rd != '0);

endmodule

//--- logic/rv32i_core.sv
// Top of the RV32I integer pipeline: decode, execute, writeback.
// One decoded instruction per cycle in, results leave 2 cycles later.
// NUM_REGS sizes the register file.

`timescale 1ns/1ps

module rv32i_core #(
    parameter int NUM_REGS = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  rv32i_pkg::word_t    instr,
    output logic                wb_valid,
    output rv32i_pkg::reg_idx_t wb_rd,
    output rv32i_pkg::word_t    wb_data
);
    import rv32i_pkg::*;

    // Decode to register file read ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    // ID/EX bundle
    id_ex_if id_ex ();

    // ------------------------------------------------------------
    // Register file, written from EX/WB
    // ------------------------------------------------------------
    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1_idx),
        .rs2      (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid),
        .wr_rd    (wb_rd),
        .wr_data  (wb_data)
    );

    // ------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------
    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1         (rs1_idx),
        .rs2         (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_ex       (id_ex)
    );

    // Writeback drives both the outputs and the file write port
    execute_stage u_execute_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

//--- logic/rv32i_pkg.sv
// Shared types for the RV32I integer pipeline.
// Imported by the interface, the RTL stages and the testbench.

package rv32i_pkg;

    // Data path width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // ------------------------------------------------------------
    // Major opcodes handled by decode
    // ------------------------------------------------------------
    // Any other 7-bit value is treated as unsupported
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111
    } opcode_e;

    // ALU operations, chosen in decode and carried to execute
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // LUI just forwards the immediate
        alu_pass_b = 4'd10
    } alu_op_e;

    // ------------------------------------------------------------
    // One instruction word, three field layouts
    // ------------------------------------------------------------
    typedef union packed {
        // Register-register
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        // Register-immediate, shift amount sits in imm[4:0]
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
        // Upper immediate
        struct packed {
            logic [19:0] imm;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u;
    } instr_u;

endpackage

//--- test/tb_clock_gen.sv
// Clock and reset source for the pipeline testbench.
// 40 ns clock, reset held low for the first 16 rising edges.

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk = ~clk;

    // Release just after an edge, like the rest of the stimulus
    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

//--- test/tb_rv32i_core.sv
// Testbench for the RV32I integer pipeline.
// Issues directed and LFSR-driven instructions, predicts each writeback
// with a reference model and checks value and 2-cycle latency.

`timescale 1ns/1ps

module tb_rv32i_core;
    import rv32i_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    word_t    instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // Architectural state as the reference model sees it
    word_t       model_regs [32];
    logic [31:0] lfsr_state;
    int unsigned cyc;
    bit          timed_out;

    // Expected writebacks, in issue order
    reg_idx_t    exp_rd_q [$];
    word_t       exp_data_q [$];
    int unsigned exp_cyc_q [$];
    word_t       exp_instr_q [$];

    int idx_errors;
    int word_errors;
    int timing_errors;
    int other_errors;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32i_core #(
        .NUM_REGS (32)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------------------------------------
    // Random source and instruction encoding
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Mostly x1..x4 so results feed each other, sometimes any index
    function automatic reg_idx_t rand_reg();
        if (take_bits(2) != 0) begin
            return reg_idx_t'(take_bits(2) + 1);
        end
        return reg_idx_t'(take_bits(5));
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, opc_lui};
    endfunction

    function automatic word_t rand_instr();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        kind = 4'(take_bits(4));
        f3   = 3'(take_bits(3));
        rs1  = rand_reg();
        rs2  = rand_reg();
        rd   = rand_reg();
        f7   = 7'h00;
        // SUB and SRA/SRAI need bit 30
        if ((f3 == 3'b000 || f3 == 3'b101) && take_bits(1) != 0) begin
            f7 = 7'h20;
        end
        if (kind <= 6) begin
            return enc_r(f7, rs2, rs1, f3, rd);
        end
        if (kind <= 12) begin
            if (f3 == 3'b001) begin
                imm = {7'h00, rs2};
            end else if (f3 == 3'b101) begin
                imm = {f7, rs2};
            end else begin
                imm = 12'(take_bits(12));
            end
            return enc_i(imm, rs1, f3, rd);
        end
        if (kind <= 14) begin
            return enc_u(20'(take_bits(20)), rd);
        end
        // Flipping bit 6 of a supported opcode gives an unsupported one
        return enc_r(f7, rs2, rs1, f3, rd) ^ 32'h40;
    endfunction

    // ------------------------------------------------------------
    // Reference model, straight from the RV32I rules
    // ------------------------------------------------------------
    function automatic void ref_exec(input word_t w, input word_t regs [32],
                                     output bit wb, output reg_idx_t rd,
                                     output word_t data);
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        logic [2:0] f3;
        rd   = w[11:7];
        f3   = w[14:12];
        a    = (w[19:15] == 0) ? '0 : regs[w[19:15]];
        b    = (w[6:0] == opc_op) ? ((w[24:20] == 0) ? '0 : regs[w[24:20]])
                                  : {{20{w[31]}}, w[31:20]};
        sh   = b[4:0];
        wb   = (w[6:0] == opc_op || w[6:0] == opc_op_imm || w[6:0] == opc_lui)
               && rd != 0;
        data = '0;
        if (w[6:0] == opc_lui) begin
            data = {w[31:12], 12'h000};
        end else begin
            case (f3)
                3'b000: data = (w[6:0] == opc_op && w[30]) ? a - b : a + b;
                3'b001: data = a << sh;
                3'b010: data = {31'b0, $signed(a) < $signed(b)};
                3'b011: data = {31'b0, a < b};
                3'b100: data = a ^ b;
                3'b101: data = w[30] ? word_t'($signed(a) >>> sh) : a >> sh;
                3'b110: data = a | b;
                default: data = a & b;
            endcase
        end
    endfunction

    // ------------------------------------------------------------
    // Compare tasks and writeback monitor
    // ------------------------------------------------------------
    task automatic check_idx(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            idx_errors++;
            $display("[ERROR] %0t: %s expected x%0d, got x%0d", $time, what, exp, got);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            word_errors++;
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp, got);
        end
    endtask

    // Sampled on the falling edge, away from DUT updates and stimulus
    always @(negedge clk) begin
        if (cyc > 0 && $isunknown(wb_valid)) begin
            other_errors++;
            $display("wb_valid is unknown at %0t after the first clock edge", $time);
        end else if (wb_valid === 1'b1) begin
            if (exp_rd_q.size() == 0) begin
                other_errors++;
                $display("Unexpected writeback to x%0d at %0t with none outstanding",
                         wb_rd, $time);
            end else begin
                if (cyc != exp_cyc_q[0]) begin
                    timing_errors++;
                    $display("[ERROR] %0t: writeback of %h in cycle %0d, expected cycle %0d",
                             $time, exp_instr_q[0], cyc, exp_cyc_q[0]);
                end
                check_idx(wb_rd, exp_rd_q[0], $sformatf("wb_rd of %h", exp_instr_q[0]));
                check_word(wb_data, exp_data_q[0], $sformatf("wb_data of %h", exp_instr_q[0]));
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_cyc_q.pop_front());
                void'(exp_instr_q.pop_front());
            end
        end else if (exp_cyc_q.size() != 0 && cyc == exp_cyc_q[0]) begin
            timing_errors++;
            $display("[ERROR] %0t: no writeback in cycle %0d for %h",
                     $time, cyc, exp_instr_q[0]);
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    // Called 2 ns after a rising edge, returns 2 ns after the next one
    task automatic issue(input word_t w);
        bit       wb;
        reg_idx_t rd;
        word_t    data;
        ref_exec(w, model_regs, wb, rd, data);
        if (wb) begin
            model_regs[rd] = data;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(data);
            // Into ID/EX at the next edge, EX/WB visible after the one after
            exp_cyc_q.push_back(cyc + 2);
            exp_instr_q.push_back(w);
        end
        instr_valid = 1'b1;
        instr       = w;
        @(posedge clk);
        #2;
    endtask

    // Bubble with a junk instruction word
    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            instr_valid = 1'b0;
            instr       = take_bits(32);
            @(posedge clk);
            #2;
        end
    endtask

    initial begin : main
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'h7bb9e4bb;
        cyc         = 0;
        timed_out   = 1'b0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end

        for (int k = 0; k < 40 && rst_n !== 1'b1; k++) begin
            @(posedge clk);
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            #2;
            idle(3);
            // Fresh registers read zero
            issue(enc_r(7'h00, 5'd7, 5'd3, 3'b000, 5'd5));
            issue(enc_i(12'h000, 5'd9, 3'b110, 5'd6));
            // LUI, then back-to-back and distance-two chains
            issue(enc_u(20'hABCDE, 5'd13));
            issue(enc_i(12'd5, 5'd0, 3'b000, 5'd1));
            issue(enc_i(12'd3, 5'd1, 3'b000, 5'd1));
            issue(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
            issue(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
            issue(enc_u(20'h80000, 5'd4));
            issue(enc_i(12'h404, 5'd4, 3'b101, 5'd5));
            issue(enc_i(12'h004, 5'd4, 3'b101, 5'd6));
            issue(enc_r(7'h00, 5'd1, 5'd4, 3'b010, 5'd7));
            issue(enc_r(7'h00, 5'd1, 5'd4, 3'b011, 5'd8));
            issue(enc_i(12'hFFF, 5'd4, 3'b010, 5'd9));
            issue(enc_i(12'hFFF, 5'd1, 3'b011, 5'd10));
            issue(enc_i(12'hFFF, 5'd5, 3'b100, 5'd11));
            issue(enc_r(7'h00, 5'd3, 5'd1, 3'b001, 5'd12));
            issue(enc_r(7'h20, 5'd3, 5'd4, 3'b101, 5'd14));
            // rd zero and unsupported opcodes leave no trace
            issue(enc_i(12'd123, 5'd1, 3'b000, 5'd0));
            issue({12'h004, 5'd2, 3'b010, 5'd5, 7'b0000011});
            issue({7'h00, 5'd3, 5'd2, 3'b000, 5'd6, 7'b1100011});
            issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd15));
            issue(enc_r(7'h00, 5'd0, 5'd5, 3'b110, 5'd16));
            issue(enc_r(7'h00, 5'd6, 5'd0, 3'b000, 5'd17));
            // Random stream with random gaps
            for (int k = 0; k < 300; k++) begin
                if (take_bits(2) == 0) begin
                    idle(int'(take_bits(2)) + 1);
                end
                issue(rand_instr());
            end
            idle(1);
            for (int k = 0; k < 20 && exp_rd_q.size() != 0; k++) begin
                @(posedge clk);
            end
            if (exp_rd_q.size() != 0) begin
                $display("Timeout: %0d expected writebacks never arrived", exp_rd_q.size());
                timed_out = 1'b1;
            end
            // A few quiet cycles to catch stray writebacks
            repeat (4) @(posedge clk);
        end

        $display("Errors: rd %0d, data %0d, timing %0d, other %0d",
                 idx_errors, word_errors, timing_errors, other_errors);
        if (timed_out || idx_errors + word_errors + timing_errors + other_errors != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule
